/* Bender.yml */
package:
  name: csr_unit

sources:
  - hw/csr_pkg.sv
  - hw/excp_decode.sv
  - hw/csr_access_decode.sv
  - hw/csr_exc_regs.sv
  - hw/csr_timer.sv
  - hw/csr_plain_regs.sv
  - hw/csr_read_port.sv
  - hw/csr_unit.sv
  - target: simulation
    files:
      - bench/csr_assertions.sv
      - bench/csr_tb.sv

/* bench/csr_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic [7:0]  excp_i,
  input logic        ertn_i,
  input logic        we_i,
  input logic        stall_i,
  input logic [31:0] rd_data_i,
  input logic        int_i,
  input logic [31:0] crmd_i
);
  import csr_pkg::*;

  // read by the testbench at the end of the run
  int unsigned err_cnt = 0;

  // entry clears IE, which masks every interrupt source
  a_int_masked_on_entry: assert property (
    @(posedge clk) disable iff (!rst_n)
      (|excp_i && !ertn_i && !we_i) |=> (!crmd_i[CRMD_IE] && !int_i)
  ) else begin
    $error("interrupt request not masked after exception entry");
    err_cnt++;
  end

  a_rd_hold: assert property (
    @(posedge clk) disable iff (!rst_n) stall_i |=> $stable(rd_data_i)
  ) else begin
    $error("read data changed during a stall");
    err_cnt++;
  end

  // ertn and a CRMD write may both override the entry
  a_excp_plv0: assert property (
    @(posedge clk) disable iff (!rst_n)
      (|excp_i && !ertn_i && !we_i) |=> (crmd_i[1:0] == 2'b00)
  ) else begin
    $error("privilege level not cleared after exception entry");
    err_cnt++;
  end

endmodule

bind csr_unit csr_assertions u_csr_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .excp_i   (excp_i),
  .ertn_i   (ertn_i),
  .we_i     (we_i),
  .stall_i  (stall_i),
  .rd_data_i(rd_data_o),
  .int_i    (int_o),
  .crmd_i   (csr_o.crmd)
);

`default_nettype wire

/* bench/csr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_tb;
  import csr_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 5;
  localparam int CYCLES_PER_OP = 64;
  localparam int MAX_OPS       = 64;
  localparam int COLS          = 5;

  localparam logic [31:0] OP_END         = 32'd0;
  localparam logic [31:0] OP_READ        = 32'd1;
  localparam logic [31:0] OP_WRITE       = 32'd2;
  localparam logic [31:0] OP_WRITE_STALL = 32'd3;
  localparam logic [31:0] OP_EXCP        = 32'd4;
  localparam logic [31:0] OP_ERTN        = 32'd5;
  localparam logic [31:0] OP_HW_INT      = 32'd6;
  localparam logic [31:0] OP_WAIT_INT    = 32'd7;
  localparam logic [31:0] OP_CNT_GAP     = 32'd8;

  logic                  clk;
  logic                  rst_n;
  logic [CSR_ADDR_W-1:0] rd_addr_i;
  logic [1:0]            rdcnt_i;
  logic                  we_i;
  logic [CSR_ADDR_W-1:0] wr_addr_i;
  logic [31:0]           wr_mask_i;
  logic [31:0]           wr_data_i;
  logic                  stall_i;
  excp_flags_t           excp_i;
  logic                  ertn_i;
  logic [31:0]           pc_i;
  logic [31:0]           vaddr_i;
  logic [7:0]            hw_int_i;
  logic [31:0]           rd_data_o;
  logic                  int_o;
  csr_view_t             csr_o;

  // five columns per operation: op, arg0, arg1, arg2, expected
  logic [31:0] td [0:MAX_OPS*COLS-1];
  int          n_ops;
  bit          ops_loaded;
  int          errors;
  int          test_errs;

  csr_unit dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_addr_i(rd_addr_i),
    .rdcnt_i  (rdcnt_i),
    .we_i     (we_i),
    .wr_addr_i(wr_addr_i),
    .wr_mask_i(wr_mask_i),
    .wr_data_i(wr_data_i),
    .stall_i  (stall_i),
    .excp_i   (excp_i),
    .ertn_i   (ertn_i),
    .pc_i     (pc_i),
    .vaddr_i  (vaddr_i),
    .hw_int_i (hw_int_i),
    .rd_data_o(rd_data_o),
    .int_o    (int_o),
    .csr_o    (csr_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      errors++;
      test_errs++;
    end
  endtask

  function automatic string op_name(input logic [31:0] op);
    case (op)
      OP_READ:        return "read";
      OP_WRITE:       return "write";
      OP_WRITE_STALL: return "stalled write";
      OP_EXCP:        return "exception";
      OP_ERTN:        return "ertn";
      OP_HW_INT:      return "hw interrupt";
      OP_WAIT_INT:    return "wait interrupt";
      OP_CNT_GAP:     return "counter gap";
      default:        return "unknown";
    endcase
  endfunction

  task automatic do_read(input logic [31:0] addr, input logic [31:0] cnt,
                         input logic [31:0] exp);
    @(posedge clk);
    rd_addr_i <= addr[CSR_ADDR_W-1:0];
    rdcnt_i   <= cnt[1:0];
    @(posedge clk);
    rdcnt_i <= RDCNT_NONE;
    @(negedge clk);
    check_value("rd_data_o", rd_data_o, exp);
  endtask

  // read first so the merge sees the current value, then read back
  task automatic do_write(input logic [31:0] addr, input logic [31:0] mask,
                          input logic [31:0] data, input logic stall,
                          input logic [31:0] exp);
    @(posedge clk);
    rd_addr_i <= addr[CSR_ADDR_W-1:0];
    rdcnt_i   <= RDCNT_NONE;
    @(posedge clk);
    we_i      <= 1'b1;
    wr_addr_i <= addr[CSR_ADDR_W-1:0];
    wr_mask_i <= mask;
    wr_data_i <= data;
    stall_i   <= stall;
    @(posedge clk);
    we_i    <= 1'b0;
    stall_i <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_value("rd_data_o", rd_data_o, exp);
  endtask

  task automatic do_excp(input logic [31:0] flags, input logic [31:0] pc,
                         input logic [31:0] vaddr, input logic [31:0] exp);
    @(posedge clk);
    excp_i  <= excp_flags_t'(flags[7:0]);
    pc_i    <= pc;
    vaddr_i <= vaddr;
    @(posedge clk);
    excp_i <= '0;
    @(negedge clk);
    // esubcode and ecode, ESTAT bits 30..16
    check_value("estat.code", {17'b0, csr_o.estat[30:16]}, exp);
  endtask

  task automatic do_ertn(input logic [31:0] exp);
    @(posedge clk);
    ertn_i <= 1'b1;
    @(posedge clk);
    ertn_i <= 1'b0;
    @(negedge clk);
    check_value("crmd", csr_o.crmd, exp);
  endtask

  task automatic poll_int(input logic [31:0] bound, input logic [31:0] exp);
    int n;
    n = 0;
    @(negedge clk);
    while (int_o !== exp[0] && n < bound) begin
      @(negedge clk);
      n++;
    end
    check_value("int_o", {31'b0, int_o}, exp);
  endtask

  // gap must be at least 2 cycles
  task automatic do_cnt_gap(input logic [31:0] gap, input logic [31:0] exp);
    logic [31:0] first;
    @(posedge clk);
    rdcnt_i <= RDCNT_LOW;
    @(posedge clk);
    rdcnt_i <= RDCNT_NONE;
    @(negedge clk);
    first = rd_data_o;
    repeat (gap - 1) @(posedge clk);
    rdcnt_i <= RDCNT_LOW;
    @(posedge clk);
    rdcnt_i <= RDCNT_NONE;
    @(negedge clk);
    check_value("cnt_lo delta", rd_data_o - first, exp);
  endtask

  task automatic run_op(input int idx);
    logic [31:0] op;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] exp;
    op  = td[idx*COLS];
    a0  = td[idx*COLS+1];
    a1  = td[idx*COLS+2];
    a2  = td[idx*COLS+3];
    exp = td[idx*COLS+4];
    case (op)
      OP_READ:        do_read(a0, a1, exp);
      OP_WRITE:       do_write(a0, a1, a2, 1'b0, exp);
      OP_WRITE_STALL: do_write(a0, a1, a2, 1'b1, exp);
      OP_EXCP:        do_excp(a0, a1, a2, exp);
      OP_ERTN:        do_ertn(exp);
      OP_HW_INT: begin
        @(posedge clk);
        hw_int_i <= a0[7:0];
        poll_int(a1, exp);
      end
      OP_WAIT_INT:    poll_int(a0, exp);
      OP_CNT_GAP:     do_cnt_gap(a0, exp);
      default: begin
        $display("unknown operation code 0x%08h in test %0d", op, idx);
        errors++;
        test_errs++;
      end
    endcase
  endtask

  initial begin
    int assert_errs;
    rst_n      = 1'b0;
    rd_addr_i  = '0;
    rdcnt_i    = RDCNT_NONE;
    we_i       = 1'b0;
    wr_addr_i  = '0;
    wr_mask_i  = '0;
    wr_data_i  = '0;
    stall_i    = 1'b0;
    excp_i     = '0;
    ertn_i     = 1'b0;
    pc_i       = '0;
    vaddr_i    = '0;
    hw_int_i   = '0;
    errors     = 0;
    n_ops      = 0;
    ops_loaded = 1'b0;

    $readmemh("bench/csr_testdata.hex", td);
    while (n_ops < MAX_OPS && td[n_ops*COLS] !== OP_END && !$isunknown(td[n_ops*COLS])) begin
      n_ops++;
    end
    ops_loaded = 1'b1;
    if (n_ops == 0) begin
      $display("no operations found in bench/csr_testdata.hex");
      errors++;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < n_ops; i++) begin
      test_errs = 0;
      run_op(i);
      $display("test %0d %s: %s", i, op_name(td[i*COLS]),
               (test_errs == 0) ? "ok" : "mismatch");
    end

    assert_errs = dut.u_csr_assertions.err_cnt;
    $display("%0d tests, %0d check errors, %0d assertion failures",
             n_ops, errors, assert_errs);
    if (errors == 0 && assert_errs == 0) begin
      $display("Regression passed");
    end
    else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog, sized from the number of operations
  initial begin
    wait (ops_loaded);
    #((n_ops * CYCLES_PER_OP + RESET_CYCLES) * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles",
             n_ops * CYCLES_PER_OP + RESET_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/csr_testdata.hex */
// columns: op arg0 arg1 arg2 expected, all 32-bit hex
// op 1 read(addr,rdcnt) 2 write(addr,mask,data) 3 stalled write 4 excp(flags,pc,vaddr)
// op 5 ertn 6 hw int(lines,bound) 7 wait int(bound) 8 counter gap(cycles) 0 end
00000001 00000000 00000000 00000000 00000008
00000001 00000030 00000000 00000000 00000000
00000001 00000005 00000000 00000000 00000000
00000007 00000001 00000000 00000000 00000000
00000002 00000030 ffffffff 12345678 12345678
00000002 00000030 0000ff00 abcdefab 1234ef78
00000003 00000030 ffffffff 00000000 1234ef78
00000002 00000002 ffffffff ffffffff 00000001
00000002 00000000 00000007 ffffffff 0000000f
00000004 00000010 1c000040 00001003 00000009
00000001 00000006 00000000 00000000 1c000040
00000001 00000007 00000000 00000000 00001003
00000001 00000000 00000000 00000000 00000008
00000001 00000001 00000000 00000000 00000007
00000005 00000000 00000000 00000000 0000000f
00000004 00000040 1c000100 00000000 00000008
00000001 00000007 00000000 00000000 1c000100
00000005 00000000 00000000 00000000 0000000f
00000004 0000001c 1c000200 00002000 00000009
00000005 00000000 00000000 00000000 0000000f
00000004 00000022 1c000300 00003000 00000048
00000001 00000007 00000000 00000000 00003000
00000005 00000000 00000000 00000000 0000000f
00000004 000000ff 1c000400 00004000 00000000
00000005 00000000 00000000 00000000 0000000f
00000002 00000040 ffffffff 000000a5 000000a5
00000001 00000000 00000001 00000000 000000a5
00000001 00000000 00000003 00000000 00000000
00000008 00000007 00000000 00000000 00000007
00000002 00000004 ffffffff 00000800 00000800
00000002 00000041 ffffffff 00000015 00000015
00000007 00000017 00000000 00000000 00000001
00000002 00000044 ffffffff 00000001 00000000
00000007 00000002 00000000 00000000 00000000
00000002 00000004 00000004 00000004 00000804
00000006 00000001 00000004 00000000 00000001
00000006 00000000 00000004 00000000 00000000
00000000 00000000 00000000 00000000 00000000

/* build.f */
hw/csr_pkg.sv
hw/excp_decode.sv
hw/csr_access_decode.sv
hw/csr_exc_regs.sv
hw/csr_timer.sv
hw/csr_plain_regs.sv
hw/csr_read_port.sv
hw/csr_unit.sv
bench/csr_assertions.sv
bench/csr_tb.sv

/* hw/csr_access_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_access_decode (
  input  logic                           we_i,
  input  logic                           stall_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] wr_addr_i,
  input  logic [31:0]                    wr_mask_i,
  input  logic [31:0]                    wr_data_i,
  input  logic [31:0]                    rd_data_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] rd_addr_i,
  input  logic [1:0]                     rdcnt_i,
  output csr_pkg::csr_wr_t               wr_o,
  output csr_pkg::csr_rd_sel_t           rd_sel_o
);
  import csr_pkg::*;

  // only the low 9 address bits decode
  assign wr_o.en   = we_i && !stall_i;
  assign wr_o.addr = {{(CSR_ADDR_W-9){1'b0}}, wr_addr_i[8:0]};
  // merge against the value read on the previous cycle
  assign wr_o.data = mask_merge(rd_data_i, wr_data_i, wr_mask_i);

  assign rd_sel_o.addr = {{(CSR_ADDR_W-9){1'b0}}, rd_addr_i[8:0]};

  always_comb begin
    case (rdcnt_i)
      RDCNT_NONE: rd_sel_o.sel = SEL_CSR;
      RDCNT_ID:   rd_sel_o.sel = SEL_CNT_ID;
      RDCNT_LOW:  rd_sel_o.sel = SEL_CNT_LO;
      RDCNT_HIGH: rd_sel_o.sel = SEL_CNT_HI;
      default:    rd_sel_o.sel = SEL_CSR;
    endcase
  end

endmodule

`default_nettype wire

/* hw/csr_exc_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_exc_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::csr_wr_t    wr_i,
  input  csr_pkg::excp_info_t info_i,
  input  logic                ertn_i,
  input  logic [31:0]         pc_i,
  input  logic [7:0]          hw_int_i,
  output logic [31:0]         crmd_o,
  output logic [31:0]         prmd_o,
  output logic [31:0]         estat_o,
  output logic [31:0]         era_o,
  output logic [31:0]         badv_o
);
  import csr_pkg::*;

  logic [31:0] crmd_q;
  logic [31:0] prmd_q;
  logic [31:0] era_q;
  logic [31:0] badv_q;
  logic [1:0]  swi_q;
  logic [7:0]  hwi_smp_q;
  logic [7:0]  hwi_q;
  logic [5:0]  ecode_q;
  logic [8:0]  esub_q;
  logic [31:0] estat_new;
  logic        crmd_we;
  logic        prmd_we;
  logic        estat_we;
  logic        era_we;
  logic        badv_we;

  assign crmd_we  = wr_i.en && (wr_i.addr == CSR_CRMD);
  assign prmd_we  = wr_i.en && (wr_i.addr == CSR_PRMD);
  assign estat_we = wr_i.en && (wr_i.addr == CSR_ESTAT);
  assign era_we   = wr_i.en && (wr_i.addr == CSR_ERA);
  assign badv_we  = wr_i.en && (wr_i.addr == CSR_BADV);

  // later assignments win: exception, then ertn, then write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q <= CRMD_RESET;
      prmd_q <= '0;
    end
    else begin
      if (info_i.valid) begin
        crmd_q[1:0]      <= 2'b0;
        crmd_q[CRMD_IE]  <= 1'b0;
        prmd_q[1:0]      <= crmd_q[1:0];
        prmd_q[PRMD_PIE] <= crmd_q[CRMD_IE];
      end
      if (ertn_i) begin
        crmd_q[1:0]     <= prmd_q[1:0];
        crmd_q[CRMD_IE] <= prmd_q[PRMD_PIE];
      end
      if (crmd_we) begin
        crmd_q <= mask_merge(crmd_q, wr_i.data, CRMD_WMASK);
      end
      if (prmd_we) begin
        prmd_q <= mask_merge(prmd_q, wr_i.data, PRMD_WMASK);
      end
    end
  end

  // bit 11 is filled in with the timer interrupt at the top level
  assign estat_o   = {1'b0, esub_q, ecode_q, 6'b0, hwi_q, swi_q};
  assign estat_new = mask_merge(estat_o, wr_i.data, ESTAT_WMASK);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      swi_q     <= '0;
      hwi_smp_q <= '0;
      hwi_q     <= '0;
      ecode_q   <= '0;
      esub_q    <= '0;
    end
    else begin
      // two stages, input sampler then ESTAT
      hwi_smp_q <= hw_int_i;
      hwi_q     <= hwi_smp_q;
      if (info_i.valid) begin
        ecode_q <= info_i.ecode;
        esub_q  <= info_i.esubcode;
      end
      if (estat_we) begin
        swi_q <= estat_new[1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      era_q  <= '0;
      badv_q <= '0;
    end
    else begin
      if (info_i.valid) begin
        era_q <= pc_i;
      end
      if (info_i.valid && info_i.badv_we) begin
        badv_q <= info_i.badv;
      end
      if (era_we) begin
        era_q <= wr_i.data;
      end
      if (badv_we) begin
        badv_q <= wr_i.data;
      end
    end
  end

  assign crmd_o = crmd_q;
  assign prmd_o = prmd_q;
  assign era_o  = era_q;
  assign badv_o = badv_q;

endmodule

`default_nettype wire

/* hw/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  localparam int CSR_ADDR_W = 14;

  // architectural addresses
  localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h000;
  localparam logic [CSR_ADDR_W-1:0] CSR_PRMD   = 14'h001;
  localparam logic [CSR_ADDR_W-1:0] CSR_EUEN   = 14'h002;
  localparam logic [CSR_ADDR_W-1:0] CSR_ECTL   = 14'h004;
  localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h005;
  localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h006;
  localparam logic [CSR_ADDR_W-1:0] CSR_BADV   = 14'h007;
  localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'h00c;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0  = 14'h030;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE1  = 14'h031;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE2  = 14'h032;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE3  = 14'h033;
  localparam logic [CSR_ADDR_W-1:0] CSR_TID    = 14'h040;
  localparam logic [CSR_ADDR_W-1:0] CSR_TCFG   = 14'h041;
  localparam logic [CSR_ADDR_W-1:0] CSR_TVAL   = 14'h042;
  localparam logic [CSR_ADDR_W-1:0] CSR_TICLR  = 14'h044;

  // DA set, everything else clear
  localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

  // writable bits per register
  localparam logic [31:0] CRMD_WMASK   = 32'h0000_01ff;
  localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
  localparam logic [31:0] EUEN_WMASK   = 32'h0000_0001;
  localparam logic [31:0] ECTL_WMASK   = 32'h0000_1bff;
  localparam logic [31:0] ESTAT_WMASK  = 32'h0000_0003;
  localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;
  localparam logic [31:0] TCFG_WMASK   = 32'hffff_ffff;

  // single-bit field positions
  localparam int CRMD_IE       = 2;
  localparam int PRMD_PIE      = 2;
  localparam int ESTAT_TI      = 11;
  localparam int TCFG_EN       = 0;
  localparam int TCFG_PERIODIC = 1;
  localparam int TICLR_CLR     = 0;

  localparam logic [5:0] ECODE_INT = 6'h00;
  localparam logic [5:0] ECODE_ADE = 6'h08;
  localparam logic [5:0] ECODE_ALE = 6'h09;
  localparam logic [5:0] ECODE_SYS = 6'h0b;
  localparam logic [5:0] ECODE_BRK = 6'h0c;
  localparam logic [5:0] ECODE_INE = 6'h0d;
  localparam logic [5:0] ECODE_IPE = 6'h0e;
  localparam logic [8:0] ESUB_ADEM = 9'd1;

  localparam logic [1:0] RDCNT_NONE = 2'd0;
  localparam logic [1:0] RDCNT_ID   = 2'd1;
  localparam logic [1:0] RDCNT_LOW  = 2'd2;
  localparam logic [1:0] RDCNT_HIGH = 2'd3;

  typedef struct packed {
    logic interrupt;
    logic adef;
    logic adem;
    logic ale;
    logic sys;
    logic brk;
    logic ine;
    logic ipe;
  } excp_flags_t;

  typedef struct packed {
    logic        valid;
    logic [5:0]  ecode;
    logic [8:0]  esubcode;
    logic        badv_we;
    logic [31:0] badv;
  } excp_info_t;

  typedef struct packed {
    logic                  en;
    logic [CSR_ADDR_W-1:0] addr;
    logic [31:0]           data;
  } csr_wr_t;

  typedef enum logic [1:0] {
    SEL_CSR,
    SEL_CNT_ID,
    SEL_CNT_LO,
    SEL_CNT_HI
  } rd_class_e;

  typedef struct packed {
    rd_class_e             sel;
    logic [CSR_ADDR_W-1:0] addr;
  } csr_rd_sel_t;

  typedef struct packed {
    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] euen;
    logic [31:0] ectl;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] badv;
    logic [31:0] eentry;
    logic [31:0] save0;
    logic [31:0] save1;
    logic [31:0] save2;
    logic [31:0] save3;
    logic [31:0] tid;
    logic [31:0] tcfg;
    logic [31:0] tval;
  } csr_view_t;

  // new bits where mask is set, old bits elsewhere
  function automatic logic [31:0] mask_merge(input logic [31:0] old_v,
                                             input logic [31:0] new_v,
                                             input logic [31:0] mask);
    return (old_v & ~mask) | (new_v & mask);
  endfunction

endpackage

`default_nettype wire

/* hw/csr_plain_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_plain_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  csr_pkg::csr_wr_t      wr_i,
  output logic [31:0]           euen_o,
  output logic [31:0]           ectl_o,
  output logic [31:0]           eentry_o,
  output logic [3:0][31:0]      save_o,
  output logic [31:0]           tid_o
);
  import csr_pkg::*;

  logic [31:0]      euen_q;
  logic [31:0]      ectl_q;
  logic [31:0]      eentry_q;
  logic [3:0][31:0] save_q;
  logic [31:0]      tid_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      euen_q   <= '0;
      ectl_q   <= '0;
      eentry_q <= '0;
      save_q   <= '0;
      tid_q    <= '0;
    end
    else if (wr_i.en) begin
      case (wr_i.addr)
        CSR_EUEN:   euen_q   <= mask_merge(euen_q, wr_i.data, EUEN_WMASK);
        CSR_ECTL:   ectl_q   <= mask_merge(ectl_q, wr_i.data, ECTL_WMASK);
        CSR_EENTRY: eentry_q <= mask_merge(eentry_q, wr_i.data, EENTRY_WMASK);
        CSR_TID:    tid_q    <= wr_i.data;
        CSR_SAVE0:  save_q[0] <= wr_i.data;
        CSR_SAVE1:  save_q[1] <= wr_i.data;
        CSR_SAVE2:  save_q[2] <= wr_i.data;
        CSR_SAVE3:  save_q[3] <= wr_i.data;
        default:    ;
      endcase
    end
  end

  assign euen_o   = euen_q;
  assign ectl_o   = ectl_q;
  assign eentry_o = eentry_q;
  assign save_o   = save_q;
  assign tid_o    = tid_q;

endmodule

`default_nettype wire

/* hw/csr_read_port.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_read_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall_i,
  input  csr_pkg::csr_rd_sel_t rd_sel_i,
  input  csr_pkg::csr_view_t   view_i,
  input  logic                 ti_i,
  input  logic [63:0]          stable_cnt_i,
  output logic [31:0]          rd_data_o,
  output logic                 int_o
);
  import csr_pkg::*;

  logic [31:0] rd_next;
  logic [10:0] pending;
  logic [10:0] enabled;

  always_comb begin
    case (rd_sel_i.sel)
      SEL_CNT_ID: rd_next = view_i.tid;
      SEL_CNT_LO: rd_next = stable_cnt_i[31:0];
      SEL_CNT_HI: rd_next = stable_cnt_i[63:32];
      default: begin
        case (rd_sel_i.addr)
          CSR_CRMD:   rd_next = view_i.crmd;
          CSR_PRMD:   rd_next = view_i.prmd;
          CSR_EUEN:   rd_next = view_i.euen;
          CSR_ECTL:   rd_next = view_i.ectl;
          CSR_ESTAT:  rd_next = {view_i.estat[31:ESTAT_TI+1], ti_i, view_i.estat[ESTAT_TI-1:0]};
          CSR_ERA:    rd_next = view_i.era;
          CSR_BADV:   rd_next = view_i.badv;
          CSR_EENTRY: rd_next = view_i.eentry;
          CSR_SAVE0:  rd_next = view_i.save0;
          CSR_SAVE1:  rd_next = view_i.save1;
          CSR_SAVE2:  rd_next = view_i.save2;
          CSR_SAVE3:  rd_next = view_i.save3;
          CSR_TID:    rd_next = view_i.tid;
          CSR_TCFG:   rd_next = view_i.tcfg;
          CSR_TVAL:   rd_next = view_i.tval;
          // TICLR and unknown addresses read 0
          default:    rd_next = '0;
        endcase
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data_o <= '0;
    end
    else if (!stall_i) begin
      rd_data_o <= rd_next;
    end
  end

  // {ti, hw[7:0], sw[1:0]} against ECTL bits 11 and 9..0
  assign pending = {ti_i, view_i.estat[9:0]};
  assign enabled = {view_i.ectl[ESTAT_TI], view_i.ectl[9:0]};
  assign int_o   = (|(pending & enabled)) && view_i.crmd[CRMD_IE];

endmodule

`default_nettype wire

/* hw/csr_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
  input  logic             clk,
  input  logic             rst_n,
  input  csr_pkg::csr_wr_t wr_i,
  output logic [31:0]      tcfg_o,
  output logic [31:0]      tval_o,
  output logic             ti_o,
  output logic [63:0]      stable_cnt_o
);
  import csr_pkg::*;

  logic [31:0] tcfg_q;
  logic [31:0] tval_q;
  logic        timer_en_q;
  logic        ti_q;
  logic [63:0] cnt_q;
  logic [31:0] tcfg_new;
  logic        tcfg_we;
  logic        ticlr_we;

  assign tcfg_we  = wr_i.en && (wr_i.addr == CSR_TCFG);
  assign ticlr_we = wr_i.en && (wr_i.addr == CSR_TICLR);
  assign tcfg_new = mask_merge(tcfg_q, wr_i.data, TCFG_WMASK);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q     <= '0;
      tval_q     <= '0;
      timer_en_q <= 1'b0;
      ti_q       <= 1'b0;
    end
    else begin
      if (tcfg_we) begin
        tcfg_q     <= tcfg_new;
        // initval field sits at [31:2], so this is initval * 4
        tval_q     <= {tcfg_new[31:2], 2'b00};
        timer_en_q <= tcfg_new[TCFG_EN];
      end
      else if (timer_en_q) begin
        if (tval_q != 32'd0) begin
          tval_q <= tval_q - 32'd1;
        end
        else begin
          ti_q <= 1'b1;
          if (tcfg_q[TCFG_PERIODIC]) begin
            tval_q <= {tcfg_q[31:2], 2'b00};
          end
          else begin
            timer_en_q <= 1'b0;
            tval_q     <= '1;
          end
        end
      end
      // clear beats a same-cycle expiry
      if (ticlr_we && wr_i.data[TICLR_CLR]) begin
        ti_q <= 1'b0;
      end
    end
  end

  // stable counter, free running
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end
    else begin
      cnt_q <= cnt_q + 64'd1;
    end
  end

  assign tcfg_o       = tcfg_q;
  assign tval_o       = tval_q;
  assign ti_o         = ti_q;
  assign stable_cnt_o = cnt_q;

endmodule

`default_nettype wire

/* hw/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] rd_addr_i,
  input  logic [1:0]                     rdcnt_i,
  input  logic                           we_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] wr_addr_i,
  input  logic [31:0]                    wr_mask_i,
  input  logic [31:0]                    wr_data_i,
  input  logic                           stall_i,
  input  csr_pkg::excp_flags_t           excp_i,
  input  logic                           ertn_i,
  input  logic [31:0]                    pc_i,
  input  logic [31:0]                    vaddr_i,
  input  logic [7:0]                     hw_int_i,
  output logic [31:0]                    rd_data_o,
  output logic                           int_o,
  output csr_pkg::csr_view_t             csr_o
);
  import csr_pkg::*;

  csr_wr_t          wr;
  csr_rd_sel_t      rd_sel;
  excp_info_t       info;
  logic [31:0]      crmd;
  logic [31:0]      prmd;
  logic [31:0]      estat;
  logic [31:0]      era;
  logic [31:0]      badv;
  logic [31:0]      euen;
  logic [31:0]      ectl;
  logic [31:0]      eentry;
  logic [3:0][31:0] save;
  logic [31:0]      tid;
  logic [31:0]      tcfg;
  logic [31:0]      tval;
  logic             ti;
  logic [63:0]      stable_cnt;

  excp_decode u_excp_decode (
    .excp_i (excp_i),
    .pc_i   (pc_i),
    .vaddr_i(vaddr_i),
    .info_o (info)
  );

  csr_access_decode u_access_decode (
    .we_i     (we_i),
    .stall_i  (stall_i),
    .wr_addr_i(wr_addr_i),
    .wr_mask_i(wr_mask_i),
    .wr_data_i(wr_data_i),
    .rd_data_i(rd_data_o),
    .rd_addr_i(rd_addr_i),
    .rdcnt_i  (rdcnt_i),
    .wr_o     (wr),
    .rd_sel_o (rd_sel)
  );

  csr_exc_regs u_exc_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (wr),
    .info_i  (info),
    .ertn_i  (ertn_i),
    .pc_i    (pc_i),
    .hw_int_i(hw_int_i),
    .crmd_o  (crmd),
    .prmd_o  (prmd),
    .estat_o (estat),
    .era_o   (era),
    .badv_o  (badv)
  );

  csr_timer u_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (wr),
    .tcfg_o      (tcfg),
    .tval_o      (tval),
    .ti_o        (ti),
    .stable_cnt_o(stable_cnt)
  );

  csr_plain_regs u_plain_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (wr),
    .euen_o  (euen),
    .ectl_o  (ectl),
    .eentry_o(eentry),
    .save_o  (save),
    .tid_o   (tid)
  );

  csr_read_port u_read_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_i     (stall_i),
    .rd_sel_i    (rd_sel),
    .view_i      (csr_o),
    .ti_i        (ti),
    .stable_cnt_i(stable_cnt),
    .rd_data_o   (rd_data_o),
    .int_o       (int_o)
  );

  assign csr_o.crmd   = crmd;
  assign csr_o.prmd   = prmd;
  assign csr_o.euen   = euen;
  assign csr_o.ectl   = ectl;
  // timer interrupt lives in the timer, shown in ESTAT bit 11
  assign csr_o.estat  = {estat[31:ESTAT_TI+1], ti, estat[ESTAT_TI-1:0]};
  assign csr_o.era    = era;
  assign csr_o.badv   = badv;
  assign csr_o.eentry = eentry;
  assign csr_o.save0  = save[0];
  assign csr_o.save1  = save[1];
  assign csr_o.save2  = save[2];
  assign csr_o.save3  = save[3];
  assign csr_o.tid    = tid;
  assign csr_o.tcfg   = tcfg;
  assign csr_o.tval   = tval;

endmodule

`default_nettype wire

/* hw/excp_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module excp_decode (
  input  csr_pkg::excp_flags_t excp_i,
  input  logic [31:0]          pc_i,
  input  logic [31:0]          vaddr_i,
  output csr_pkg::excp_info_t  info_o
);
  import csr_pkg::*;

  always_comb begin
    info_o       = '0;
    info_o.valid = |excp_i;
    // interrupt first, ipe last
    if (excp_i.interrupt) begin
      info_o.ecode = ECODE_INT;
    end
    else if (excp_i.adef) begin
      info_o.ecode   = ECODE_ADE;
      info_o.badv_we = 1'b1;
      info_o.badv    = pc_i;
    end
    else if (excp_i.adem) begin
      info_o.ecode    = ECODE_ADE;
      info_o.esubcode = ESUB_ADEM;
      info_o.badv_we  = 1'b1;
      info_o.badv     = vaddr_i;
    end
    else if (excp_i.ale) begin
      info_o.ecode   = ECODE_ALE;
      info_o.badv_we = 1'b1;
      info_o.badv    = vaddr_i;
    end
    else if (excp_i.sys) begin
      info_o.ecode = ECODE_SYS;
    end
    else if (excp_i.brk) begin
      info_o.ecode = ECODE_BRK;
    end
    else if (excp_i.ine) begin
      info_o.ecode = ECODE_INE;
    end
    else if (excp_i.ipe) begin
      info_o.ecode = ECODE_IPE;
    end
  end

endmodule

`default_nettype wire
